/* hw/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define XLEN       32
`define COMMIT_W   4
`define CSR_ADDR_W 12

// machine trap setup and handling
`define ADDR_MSTATUS       12'h300
`define ADDR_MISA          12'h301
`define ADDR_MTVEC         12'h305
`define ADDR_MCOUNTEREN    12'h306
`define ADDR_MCOUNTINHIBIT 12'h320
`define ADDR_MSCRATCH      12'h340
`define ADDR_MEPC          12'h341
`define ADDR_MCAUSE        12'h342
`define ADDR_MTVAL         12'h343

// counters, machine view then user read-only view
`define ADDR_MCYCLE        12'hB00
`define ADDR_MINSTRET      12'hB02
`define ADDR_MCYCLEH       12'hB80
`define ADDR_MINSTRETH     12'hB82
`define ADDR_CYCLE         12'hC00
`define ADDR_INSTRET       12'hC02
`define ADDR_CYCLEH        12'hC80
`define ADDR_INSTRETH      12'hC82

`define ADDR_MARCHID       12'hF12

`define ADDR_FFLAGS        12'h001
`define ADDR_FRM           12'h002
`define ADDR_FCSR          12'h003

`define MISA_VALUE    32'h4010_1121 // rv32 i m a f u
`define MARCHID_VALUE 32'h0000_0019

// mstatus field positions
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7
`define MSTATUS_MPP_LO 11

`endif

/* hw/csrPkg.sv */
package csrPkg;

    typedef enum logic [2:0] {
        OP_R,
        OP_RW,
        OP_RS,
        OP_RC,
        OP_RWI,
        OP_RSI,
        OP_RCI,
        OP_MRET
    } csrOp;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } privLevel;

    typedef enum logic [1:0] {
        FLAG_NONE,
        FLAG_ORDERING,  // write, later ops must see it
        FLAG_ILLEGAL,
        FLAG_XRET
    } resFlag;

    // user counter aliases share the machine id
    typedef enum logic [4:0] {
        ID_NONE,
        ID_MSTATUS,
        ID_MISA,
        ID_MTVEC,
        ID_MSCRATCH,
        ID_MEPC,
        ID_MCAUSE,
        ID_MTVAL,
        ID_MCOUNTEREN,
        ID_MCOUNTINHIBIT,
        ID_MCYCLE,
        ID_MCYCLEH,
        ID_MINSTRET,
        ID_MINSTRETH,
        ID_MARCHID,
        ID_FFLAGS,
        ID_FRM,
        ID_FCSR
    } csrId;

endpackage

/* hw/csrAccess.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csrAccess import csrPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   uopValid,
    input  csrOp                   uopOp,
    input  logic [`CSR_ADDR_W-1:0] uopAddr,
    input  logic [`XLEN-1:0]       uopSrc,
    input  logic [4:0]             uopImm,
    input  logic [4:0]             uopDst,
    input  privLevel               priv,
    input  logic [`XLEN-1:0]       regRdData,
    input  logic [`XLEN-1:0]       cntRdData,
    input  logic [2:0]             cntEnable,
    output csrId                   rdId,
    output logic                   wrEn,
    output csrId                   wrId,
    output logic [`XLEN-1:0]       wrData,
    output logic                   mretEn,
    output logic                   resValid,
    output logic [`XLEN-1:0]       resData,
    output csrPkg::resFlag         resFlag
);

    csrId             addrId;
    logic             userAlias;
    logic [1:0]       aliasBit;
    logic             isMret;
    logic             isWrite;
    logic             isImm;
    logic             isReplace;
    logic             illegal;
    logic [`XLEN-1:0] rdData;
    logic [`XLEN-1:0] operand;
    logic [`XLEN-1:0] resDataNext;
    csrPkg::resFlag   flagNext;

    // address decode
    always_comb begin
        addrId = ID_NONE;
        userAlias = 1'b0;
        aliasBit = 2'd0;
        case (uopAddr)
            `ADDR_MSTATUS:       addrId = ID_MSTATUS;
            `ADDR_MISA:          addrId = ID_MISA;
            `ADDR_MTVEC:         addrId = ID_MTVEC;
            `ADDR_MSCRATCH:      addrId = ID_MSCRATCH;
            `ADDR_MEPC:          addrId = ID_MEPC;
            `ADDR_MCAUSE:        addrId = ID_MCAUSE;
            `ADDR_MTVAL:         addrId = ID_MTVAL;
            `ADDR_MCOUNTEREN:    addrId = ID_MCOUNTEREN;
            `ADDR_MCOUNTINHIBIT: addrId = ID_MCOUNTINHIBIT;
            `ADDR_MCYCLE:        addrId = ID_MCYCLE;
            `ADDR_MCYCLEH:       addrId = ID_MCYCLEH;
            `ADDR_MINSTRET:      addrId = ID_MINSTRET;
            `ADDR_MINSTRETH:     addrId = ID_MINSTRETH;
            `ADDR_MARCHID:       addrId = ID_MARCHID;
            `ADDR_FFLAGS:        addrId = ID_FFLAGS;
            `ADDR_FRM:           addrId = ID_FRM;
            `ADDR_FCSR:          addrId = ID_FCSR;
            `ADDR_CYCLE, `ADDR_CYCLEH: begin
                addrId = (uopAddr == `ADDR_CYCLE) ? ID_MCYCLE : ID_MCYCLEH;
                userAlias = 1'b1;
                aliasBit = 2'd0;
            end
            `ADDR_INSTRET, `ADDR_INSTRETH: begin
                addrId = (uopAddr == `ADDR_INSTRET) ? ID_MINSTRET : ID_MINSTRETH;
                userAlias = 1'b1;
                aliasBit = 2'd2;
            end
            default: addrId = ID_NONE;
        endcase
    end

    assign isMret = (uopOp == OP_MRET);
    assign isWrite = !isMret && (uopOp != OP_R);
    assign isImm = (uopOp == OP_RWI) || (uopOp == OP_RSI) || (uopOp == OP_RCI);
    assign isReplace = (uopOp == OP_RW) || (uopOp == OP_RWI);

    always_comb begin
        if (isMret) begin
            illegal = (priv != PRIV_MACHINE);
        end else begin
            illegal = (addrId == ID_NONE)
                || (uopAddr[9:8] > priv)
                || (isWrite && uopAddr[11:10] == 2'b11)    // read-only space
                || (userAlias && priv == PRIV_USER && !cntEnable[aliasBit]);
        end
    end

    // blocks drive zero for ids they do not own
    assign rdData = regRdData | cntRdData;
    assign operand = isImm ? {{(`XLEN-5){1'b0}}, uopImm} : uopSrc;

    always_comb begin
        case (uopOp)
            OP_RW, OP_RWI: wrData = operand;
            OP_RS, OP_RSI: wrData = rdData | operand;
            OP_RC, OP_RCI: wrData = rdData & ~operand;
            default:       wrData = rdData;
        endcase
    end

    assign rdId = addrId;
    assign wrId = addrId;
    assign wrEn = uopValid && isWrite && !illegal;
    assign mretEn = uopValid && isMret && !illegal;

    always_comb begin
        if (illegal) begin
            flagNext = FLAG_ILLEGAL;
        end else if (isMret) begin
            flagNext = FLAG_XRET;
        end else if (isWrite) begin
            flagNext = FLAG_ORDERING;
        end else begin
            flagNext = FLAG_NONE;
        end
    end

    always_comb begin
        if (illegal || isMret) begin
            resDataNext = '0;
        end else if (isReplace && uopDst == 5'd0) begin
            resDataNext = '0;   // csrw with x0, no read
        end else begin
            resDataNext = rdData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= uopValid;
        end
    end

    always_ff @(posedge clk) begin
        if (uopValid) begin
            resData <= resDataNext;
            resFlag <= flagNext;
        end
    end

endmodule

/* hw/csrRegs.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csrRegs import csrPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  csrId             rdId,
    input  logic             wrEn,
    input  csrId             wrId,
    input  logic [`XLEN-1:0] wrData,
    input  logic             mretEn,
    input  logic             trapValid,
    input  logic [`XLEN-1:0] trapPc,
    input  logic [3:0]       trapCause,
    input  logic             trapIsInterrupt,
    input  logic [4:0]       fpNewFlags,
    output logic [`XLEN-1:0] regRdData,
    output privLevel         priv,
    output logic [`XLEN-1:0] trapVec,
    output logic [`XLEN-2:0] retVec,
    output logic [2:0]       fRoundMode
);

    logic             statusMie;
    logic             statusMpie;
    privLevel         statusMpp;
    privLevel         mppWr;
    logic [`XLEN-1:0] mstatusRd;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mtval;
    logic [4:0]       fflags;
    logic [4:0]       fflagsBase;
    logic [2:0]       frm;

    always_comb begin
        mstatusRd = '0;
        mstatusRd[`MSTATUS_MIE] = statusMie;
        mstatusRd[`MSTATUS_MPIE] = statusMpie;
        mstatusRd[`MSTATUS_MPP_LO +: 2] = statusMpp;
    end

    // only U and M exist, anything else lands on U
    assign mppWr = (wrData[`MSTATUS_MPP_LO +: 2] == 2'b11) ? PRIV_MACHINE : PRIV_USER;

    always_comb begin
        fflagsBase = fflags;
        if (wrEn && (wrId == ID_FFLAGS || wrId == ID_FCSR)) begin
            fflagsBase = wrData[4:0];
        end
    end

    always_comb begin
        case (rdId)
            ID_MSTATUS:  regRdData = mstatusRd;
            ID_MISA:     regRdData = `MISA_VALUE;
            ID_MTVEC:    regRdData = mtvec;
            ID_MSCRATCH: regRdData = mscratch;
            ID_MEPC:     regRdData = mepc;
            ID_MCAUSE:   regRdData = mcause;
            ID_MTVAL:    regRdData = mtval;
            ID_MARCHID:  regRdData = `MARCHID_VALUE;
            ID_FFLAGS:   regRdData = {{(`XLEN-5){1'b0}}, fflags};
            ID_FRM:      regRdData = {{(`XLEN-3){1'b0}}, frm};
            ID_FCSR:     regRdData = {{(`XLEN-8){1'b0}}, frm, fflags};
            default:     regRdData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_MACHINE;
            statusMie <= 1'b0;
            statusMpie <= 1'b0;
            statusMpp <= PRIV_USER;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            fflags <= '0;
            frm <= '0;
            retVec <= '0;
        end else begin
            fflags <= fflagsBase | fpNewFlags; // sticky
            if (wrEn) begin
                case (wrId)
                    ID_MSTATUS: begin
                        statusMie <= wrData[`MSTATUS_MIE];
                        statusMpie <= wrData[`MSTATUS_MPIE];
                        statusMpp <= mppWr;
                    end
                    ID_MTVEC:    mtvec <= wrData;
                    ID_MSCRATCH: mscratch <= wrData;
                    ID_MEPC:     mepc <= {wrData[`XLEN-1:1], 1'b0};
                    ID_MCAUSE:   mcause <= {wrData[`XLEN-1], {(`XLEN-6){1'b0}}, wrData[4:0]};
                    ID_MTVAL:    mtval <= wrData;
                    ID_FRM:      frm <= wrData[2:0];
                    ID_FCSR:     frm <= wrData[7:5];
                    default: begin
                    end
                endcase
            end
            if (mretEn) begin
                statusMie <= statusMpie;
                statusMpp <= PRIV_USER;
                priv <= statusMpp;
                retVec <= mepc[`XLEN-1:1];
            end
            // trap comes last so it overrides a same-cycle write
            if (trapValid) begin
                statusMpie <= statusMie;
                statusMie <= 1'b0;
                statusMpp <= priv;
                mepc <= {trapPc[`XLEN-1:1], 1'b0};
                mcause <= {trapIsInterrupt, {(`XLEN-5){1'b0}}, trapCause};
                mtval <= '0;
                priv <= PRIV_MACHINE;
            end
        end
    end

    assign trapVec = mtvec;
    assign fRoundMode = frm;

endmodule

/* hw/counterBank.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module counterBank import csrPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  csrId                 rdId,
    input  logic                 wrEn,
    input  csrId                 wrId,
    input  logic [`XLEN-1:0]     wrData,
    input  logic [`COMMIT_W-1:0] commitValid,
    output logic [`XLEN-1:0]     cntRdData,
    output logic [2:0]           cntEnable
);

    localparam int CNT_W = $clog2(`COMMIT_W + 1);

    logic [63:0]      mcycle;
    logic [63:0]      minstret;
    logic [2:0]       mcounteren;     // bit 1 (time) tied low
    logic [2:0]       mcountinhibit;
    logic [CNT_W-1:0] commitCount;

    always_comb begin
        commitCount = '0;
        for (int i = 0; i < `COMMIT_W; i++) begin
            commitCount = commitCount + CNT_W'(commitValid[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
            mcounteren <= '0;
            mcountinhibit <= '0;
        end else begin
            // a write replaces this edge's increment
            if (wrEn && wrId == ID_MCYCLE) begin
                mcycle[31:0] <= wrData;
            end else if (wrEn && wrId == ID_MCYCLEH) begin
                mcycle[63:32] <= wrData;
            end else if (!mcountinhibit[0]) begin
                mcycle <= mcycle + 64'd1;
            end

            if (wrEn && wrId == ID_MINSTRET) begin
                minstret[31:0] <= wrData;
            end else if (wrEn && wrId == ID_MINSTRETH) begin
                minstret[63:32] <= wrData;
            end else if (!mcountinhibit[2]) begin
                minstret <= minstret + 64'(commitCount);
            end

            if (wrEn && wrId == ID_MCOUNTEREN) begin
                mcounteren <= {wrData[2], 1'b0, wrData[0]};
            end
            if (wrEn && wrId == ID_MCOUNTINHIBIT) begin
                mcountinhibit <= {wrData[2], 1'b0, wrData[0]};
            end
        end
    end

    always_comb begin
        case (rdId)
            ID_MCYCLE:        cntRdData = mcycle[31:0];
            ID_MCYCLEH:       cntRdData = mcycle[63:32];
            ID_MINSTRET:      cntRdData = minstret[31:0];
            ID_MINSTRETH:     cntRdData = minstret[63:32];
            ID_MCOUNTEREN:    cntRdData = {{(`XLEN-3){1'b0}}, mcounteren};
            ID_MCOUNTINHIBIT: cntRdData = {{(`XLEN-3){1'b0}}, mcountinhibit};
            default:          cntRdData = '0;
        endcase
    end

    assign cntEnable = mcounteren;

endmodule

/* hw/csrUnit.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csrUnit import csrPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   uopValid,
    input  csrOp                   uopOp,
    input  logic [`CSR_ADDR_W-1:0] uopAddr,
    input  logic [`XLEN-1:0]       uopSrc,
    input  logic [4:0]             uopImm,
    input  logic [4:0]             uopDst,
    output logic                   resValid,
    output logic [`XLEN-1:0]       resData,
    output csrPkg::resFlag         resFlag,
    input  logic                   trapValid,
    input  logic [`XLEN-1:0]       trapPc,
    input  logic [3:0]             trapCause,
    input  logic                   trapIsInterrupt,
    input  logic [4:0]             fpNewFlags,
    input  logic [`COMMIT_W-1:0]   commitValid,
    output privLevel               priv,
    output logic [`XLEN-1:0]       trapVec,
    output logic [`XLEN-2:0]       retVec,
    output logic [2:0]             fRoundMode
);

    csrId             rdId;
    csrId             wrId;
    logic             wrEn;
    logic [`XLEN-1:0] wrData;
    logic             mretEn;
    logic [`XLEN-1:0] regRdData;
    logic [`XLEN-1:0] cntRdData;
    logic [2:0]       cntEnable;

    csrAccess access_inst (
        .clk(clk), .rst(rst),
        .uopValid(uopValid), .uopOp(uopOp), .uopAddr(uopAddr),
        .uopSrc(uopSrc), .uopImm(uopImm), .uopDst(uopDst),
        .priv(priv), .regRdData(regRdData), .cntRdData(cntRdData), .cntEnable(cntEnable),
        .rdId(rdId), .wrEn(wrEn), .wrId(wrId), .wrData(wrData), .mretEn(mretEn),
        .resValid(resValid), .resData(resData), .resFlag(resFlag)
    );

    csrRegs regs_inst (
        .clk(clk), .rst(rst),
        .rdId(rdId), .wrEn(wrEn), .wrId(wrId), .wrData(wrData), .mretEn(mretEn),
        .trapValid(trapValid), .trapPc(trapPc), .trapCause(trapCause),
        .trapIsInterrupt(trapIsInterrupt), .fpNewFlags(fpNewFlags),
        .regRdData(regRdData), .priv(priv), .trapVec(trapVec),
        .retVec(retVec), .fRoundMode(fRoundMode)
    );

    counterBank counters_inst (
        .clk(clk), .rst(rst),
        .rdId(rdId), .wrEn(wrEn), .wrId(wrId), .wrData(wrData),
        .commitValid(commitValid),
        .cntRdData(cntRdData), .cntEnable(cntEnable)
    );

endmodule

/* dv/csrUnitTb.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csrUnitTb import csrPkg::*; ();

    localparam logic [31:0] SEED = 32'h8af;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NUM_TESTS = 5;
    localparam int COMMIT_CYCLES = 24;

    logic                   clk;
    logic                   rst;
    logic                   uopValid;
    csrOp                   uopOp;
    logic [`CSR_ADDR_W-1:0] uopAddr;
    logic [`XLEN-1:0]       uopSrc;
    logic [4:0]             uopImm;
    logic [4:0]             uopDst;
    logic                   resValid;
    logic [`XLEN-1:0]       resData;
    resFlag                 resFlagOut;
    logic                   trapValid;
    logic [`XLEN-1:0]       trapPc;
    logic [3:0]             trapCause;
    logic                   trapIsInterrupt;
    logic [4:0]             fpNewFlags;
    logic [`COMMIT_W-1:0]   commitValid;
    privLevel               priv;
    logic [`XLEN-1:0]       trapVec;
    logic [`XLEN-2:0]       retVec;
    logic [2:0]             fRoundMode;

    logic [31:0] lfsr;
    string       curTest;
    int          errCount = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;

    csrUnit csrUnit_inst (
        .clk(clk), .rst(rst),
        .uopValid(uopValid), .uopOp(uopOp), .uopAddr(uopAddr),
        .uopSrc(uopSrc), .uopImm(uopImm), .uopDst(uopDst),
        .resValid(resValid), .resData(resData), .resFlag(resFlagOut),
        .trapValid(trapValid), .trapPc(trapPc), .trapCause(trapCause),
        .trapIsInterrupt(trapIsInterrupt), .fpNewFlags(fpNewFlags),
        .commitValid(commitValid), .priv(priv), .trapVec(trapVec),
        .retVec(retVec), .fRoundMode(fRoundMode)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextRand(input int nBits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nBits; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkField(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s %s: expected %h, actual %h", curTest, what, exp, act);
            errCount++;
        end
    endtask

    // result sampled on the falling edge after the DUT edge
    task automatic runOp(input csrOp op, input logic [11:0] addr, input logic [31:0] src,
                         input logic [4:0] imm, input logic [4:0] dst, input resFlag expFlag,
                         input logic [31:0] expData, input bit checkData);
        @(posedge clk);
        uopValid <= 1'b1;
        uopOp <= op;
        uopAddr <= addr;
        uopSrc <= src;
        uopImm <= imm;
        uopDst <= dst;
        @(posedge clk);
        uopValid <= 1'b0;
        @(negedge clk);
        assert (resValid === 1'b1) else begin
            $display("%s: no result strobe one cycle after the operation", curTest);
            errCount++;
        end
        checkField("flag", 32'(expFlag), 32'(resFlagOut));
        if (checkData) begin
            checkField("data", expData, resData);
        end
    endtask

    task automatic pulseTrap(input logic [31:0] pc, input logic [3:0] cause, input logic intr);
        @(posedge clk);
        trapValid <= 1'b1;
        trapPc <= pc;
        trapCause <= cause;
        trapIsInterrupt <= intr;
        @(posedge clk);
        trapValid <= 1'b0;
    endtask

    task automatic pulseFlags(input logic [4:0] f);
        @(posedge clk);
        fpNewFlags <= f;
        @(posedge clk);
        fpNewFlags <= '0;
    endtask

    task automatic checkPriv(input privLevel exp);
        @(negedge clk);
        checkField("priv", 32'(exp), 32'(priv));
    endtask

    task automatic finishTest(input int errBefore);
        if (errCount == errBefore) begin
            $display("test %s: pass", curTest);
        end else begin
            $display("test %s: fail, %0d bad checks", curTest, errCount - errBefore);
            testsFailed++;
        end
    endtask

    task automatic rmwOne(input logic [11:0] addr);
        logic [31:0] model;
        logic [31:0] v;
        model = '0;
        v = nextRand(32);
        runOp(OP_RW, addr, v, 5'd0, 5'd1, FLAG_ORDERING, model, 1'b1);
        model = v;
        v = nextRand(32);
        runOp(OP_RS, addr, v, 5'd0, 5'd1, FLAG_ORDERING, model, 1'b1);
        model = model | v;
        v = nextRand(32);
        runOp(OP_RC, addr, v, 5'd0, 5'd1, FLAG_ORDERING, model, 1'b1);
        model = model & ~v;
        v = nextRand(5);
        runOp(OP_RWI, addr, '0, v[4:0], 5'd1, FLAG_ORDERING, model, 1'b1);
        model = {27'd0, v[4:0]};
        v = nextRand(5);
        runOp(OP_RSI, addr, '0, v[4:0], 5'd1, FLAG_ORDERING, model, 1'b1);
        model = model | {27'd0, v[4:0]};
        v = nextRand(5);
        runOp(OP_RCI, addr, '0, v[4:0], 5'd1, FLAG_ORDERING, model, 1'b1);
        model = model & ~{27'd0, v[4:0]};
        runOp(OP_R, addr, '0, 5'd0, 5'd1, FLAG_NONE, model, 1'b1);
        v = nextRand(32);
        runOp(OP_RW, addr, v, 5'd0, 5'd0, FLAG_ORDERING, 32'd0, 1'b1); // x0 dest reads nothing
        runOp(OP_R, addr, '0, 5'd0, 5'd1, FLAG_NONE, v, 1'b1);
    endtask

    task automatic testRmw();
        int errBefore;
        errBefore = errCount;
        curTest = "rmw";
        rmwOne(`ADDR_MSCRATCH);
        rmwOne(`ADDR_MTVAL);
        finishTest(errBefore);
    endtask

    task automatic testFp();
        int errBefore;
        logic [4:0] acc;
        logic [4:0] f;
        logic [2:0] rm;
        errBefore = errCount;
        curTest = "fp";
        acc = '0;
        for (int i = 0; i < 4; i++) begin
            f = nextRand(5);
            pulseFlags(f);
            acc = acc | f;
        end
        runOp(OP_R, `ADDR_FFLAGS, '0, 5'd0, 5'd1, FLAG_NONE, {27'd0, acc}, 1'b1);
        rm = nextRand(3);
        runOp(OP_RW, `ADDR_FRM, {29'd0, rm}, 5'd0, 5'd1, FLAG_ORDERING, 32'd0, 1'b1);
        checkField("fRoundMode", {29'd0, rm}, {29'd0, fRoundMode});
        runOp(OP_R, `ADDR_FCSR, '0, 5'd0, 5'd1, FLAG_NONE, {24'd0, rm, acc}, 1'b1);
        finishTest(errBefore);
    endtask

    task automatic testTrap();
        int errBefore;
        logic [31:0] vec;
        logic [31:0] pc;
        logic [3:0]  cause;
        logic        intr;
        logic [31:0] status;
        errBefore = errCount;
        curTest = "trap";
        runOp(OP_RSI, `ADDR_MSTATUS, '0, 5'd8, 5'd1, FLAG_ORDERING, 32'd0, 1'b1); // MIE
        vec = nextRand(32);
        runOp(OP_RW, `ADDR_MTVEC, vec, 5'd0, 5'd1, FLAG_ORDERING, 32'd0, 1'b1);
        checkField("trapVec", vec, trapVec);
        pc = nextRand(32);
        cause = nextRand(4);
        intr = nextRand(1);
        pulseTrap(pc, cause, intr);
        checkPriv(PRIV_MACHINE);
        runOp(OP_R, `ADDR_MEPC, '0, 5'd0, 5'd1, FLAG_NONE, {pc[31:1], 1'b0}, 1'b1);
        runOp(OP_R, `ADDR_MCAUSE, '0, 5'd0, 5'd1, FLAG_NONE, {intr, 27'd0, cause}, 1'b1);
        status = (32'd1 << 7) | (32'd3 << 11); // MPIE set, MPP machine, MIE clear
        runOp(OP_R, `ADDR_MSTATUS, '0, 5'd0, 5'd1, FLAG_NONE, status, 1'b1);
        runOp(OP_RC, `ADDR_MSTATUS, 32'h1800, 5'd0, 5'd1, FLAG_ORDERING, status, 1'b1);
        runOp(OP_MRET, 12'h000, '0, 5'd0, 5'd0, FLAG_XRET, 32'd0, 1'b1);
        checkField("retVec", {1'b0, pc[31:1]}, {1'b0, retVec});
        checkField("priv", 32'(PRIV_USER), 32'(priv));
        finishTest(errBefore);
    endtask

    task automatic testLegal();
        int errBefore;
        errBefore = errCount;
        curTest = "legal";
        checkPriv(PRIV_USER);
        runOp(OP_R, `ADDR_MSCRATCH, '0, 5'd0, 5'd1, FLAG_ILLEGAL, 32'd0, 1'b1);
        runOp(OP_R, `ADDR_CYCLE, '0, 5'd0, 5'd1, FLAG_ILLEGAL, 32'd0, 1'b1);
        runOp(OP_MRET, 12'h000, '0, 5'd0, 5'd0, FLAG_ILLEGAL, 32'd0, 1'b1);
        pulseTrap(nextRand(32), nextRand(4), 1'b0);
        checkPriv(PRIV_MACHINE);
        runOp(OP_RSI, `ADDR_MCOUNTEREN, '0, 5'd1, 5'd1, FLAG_ORDERING, 32'd0, 1'b1);
        runOp(OP_MRET, 12'h000, '0, 5'd0, 5'd0, FLAG_XRET, 32'd0, 1'b1);
        checkField("priv", 32'(PRIV_USER), 32'(priv));
        runOp(OP_R, `ADDR_CYCLE, '0, 5'd0, 5'd1, FLAG_NONE, 32'd0, 1'b0); // value free-running
        pulseTrap(nextRand(32), nextRand(4), 1'b0);
        checkPriv(PRIV_MACHINE);
        runOp(OP_RW, 12'hC00, nextRand(32), 5'd0, 5'd1, FLAG_ILLEGAL, 32'd0, 1'b1);
        runOp(OP_R, 12'h345, '0, 5'd0, 5'd1, FLAG_ILLEGAL, 32'd0, 1'b1);
        finishTest(errBefore);
    endtask

    task automatic testCounters();
        int errBefore;
        int sum;
        logic [31:0] v;
        logic [3:0]  c;
        errBefore = errCount;
        curTest = "counters";
        runOp(OP_RWI, `ADDR_MCOUNTINHIBIT, '0, 5'd1, 5'd1, FLAG_ORDERING, 32'd0, 1'b1);
        v = nextRand(32);
        runOp(OP_RW, `ADDR_MCYCLE, v, 5'd0, 5'd1, FLAG_ORDERING, 32'd0, 1'b0);
        runOp(OP_R, `ADDR_MCYCLE, '0, 5'd0, 5'd1, FLAG_NONE, v, 1'b1);
        repeat (4) @(posedge clk);
        runOp(OP_R, `ADDR_MCYCLE, '0, 5'd0, 5'd1, FLAG_NONE, v, 1'b1);
        runOp(OP_RWI, `ADDR_MCOUNTINHIBIT, '0, 5'd0, 5'd1, FLAG_ORDERING, 32'd1, 1'b1);
        runOp(OP_RW, `ADDR_MINSTRET, 32'd0, 5'd0, 5'd1, FLAG_ORDERING, 32'd0, 1'b0);
        sum = 0;
        for (int i = 0; i < COMMIT_CYCLES; i++) begin
            @(posedge clk);
            c = nextRand(4);
            commitValid <= c;
            for (int b = 0; b < 4; b++) begin
                sum += c[b];
            end
        end
        @(posedge clk);
        commitValid <= '0;
        runOp(OP_R, `ADDR_MINSTRET, '0, 5'd0, 5'd1, FLAG_NONE, 32'(sum), 1'b1);
        finishTest(errBefore);
    endtask

    initial begin
        rst = 1'b1;
        uopValid = 1'b0;
        uopOp = OP_R;
        uopAddr = '0;
        uopSrc = '0;
        uopImm = '0;
        uopDst = '0;
        trapValid = 1'b0;
        trapPc = '0;
        trapCause = '0;
        trapIsInterrupt = 1'b0;
        fpNewFlags = '0;
        commitValid = '0;
        lfsr = SEED;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testRmw();
        testFp();
        testTrap();
        testLegal();
        testCounters();
        $display("%0d tests run, %0d failed, %0d bad checks", NUM_TESTS, testsFailed, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hw
hw/csrPkg.sv
hw/csrAccess.sv
hw/csrRegs.sv
hw/counterBank.sv
hw/csrUnit.sv
dv/csrUnitTb.sv
